//--- Makefile
# Verilator simulation of the convolution accelerator

TOP             ?= tb_conv_accel
LOG             ?= sim.log
BUILD_DIR       ?= obj_dir
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f verilog.f
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/tb_conv_accel.sv
`include "conv_defines.svh"

module tb_conv_accel
    import conv_pkg::*;
    import axil_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int FM = `CONV_FM_DIM;
    localparam int WT = `CONV_WT_DIM;
    localparam int DEPTH = `CONV_MEM_DEPTH;
    localparam int HS_LIMIT = 50;          // cycles per handshake before giving up
    localparam int DONE_POLLS = 400;       // status reads before a run counts as stuck
    localparam int N_RUNS = 4;
    localparam int RUN_CYCLES = 600;
    localparam int N_XFERS = 2000;
    localparam int XFER_CYCLES = 6;
    localparam int TIMEOUT_NS = 4 * (N_RUNS * RUN_CYCLES + N_XFERS * XFER_CYCLES) * 10;

    logic       clk;
    logic       arst_n_i;
    axil_addr_t s_awaddr_i;
    logic       s_awvalid_i;
    logic       s_awready_o;
    axil_data_t s_wdata_i;
    logic       s_wvalid_i;
    logic       s_wready_o;
    axil_resp_t s_bresp_o;
    logic       s_bvalid_o;
    logic       s_bready_i;
    axil_addr_t s_araddr_i;
    logic       s_arvalid_i;
    logic       s_arready_o;
    axil_data_t s_rdata_o;
    axil_resp_t s_rresp_o;
    logic       s_rvalid_o;
    logic       s_rready_i;

    int          error_count;
    string       test_name;
    logic [15:0] lfsr_q;
    word_t       mem_img [DEPTH];   // expected scratch contents
    word_t       wt_arr [WT*WT];
    word_t       ifm_arr [FM*FM];
    word_t       exp_arr [FM*FM];

    conv_accel_top i_conv_accel_top (.*);

    always #5 clk = !clk;

    initial begin
        #TIMEOUT_NS;
        $display("timeout: the run did not finish in %0d ns", TIMEOUT_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output word_t v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    task automatic rand_small(output word_t v);
        word_t b;
        rand_bits(4, b);
        v = {{28{b[3]}}, b[3:0]};   // signed -8..7
    endtask

    function automatic word_t fill_word(input int a);
        fill_word = {a[7:0] ^ 8'h5A, 8'hC3, ~a[7:0], a[7:0]};
    endfunction

    task automatic check_word(input string what, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_resp(input string what, input axil_resp_t expected,
                              input axil_resp_t actual);
        if (expected !== actual) begin
            $display("[ERROR] %s %s resp: expected %0d, actual %0d", test_name, what,
                     expected, actual);
            error_count++;
        end
    endtask

    task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                              output axil_resp_t resp);
        int   waited;
        logic aw_acc;
        logic w_acc;
        waited = 0;
        @(negedge clk);
        s_awaddr_i  = addr;
        s_awvalid_i = 1'b1;
        s_wdata_i   = data;
        s_wvalid_i  = 1'b1;
        while ((s_awvalid_i || s_wvalid_i) && waited < HS_LIMIT) begin
            aw_acc = s_awready_o;   // ready only moves on posedge
            w_acc  = s_wready_o;
            @(negedge clk);
            if (aw_acc) begin
                s_awvalid_i = 1'b0;
            end
            if (w_acc) begin
                s_wvalid_i = 1'b0;
            end
            waited++;
        end
        if (s_awvalid_i || s_wvalid_i) begin
            $display("%s: write address or data never accepted at %h", test_name, addr);
            error_count++;
            s_awvalid_i = 1'b0;
            s_wvalid_i  = 1'b0;
        end
        s_bready_i = 1'b1;
        waited = 0;
        while (!s_bvalid_o && waited < HS_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!s_bvalid_o) begin
            $display("%s: no write response for address %h", test_name, addr);
            error_count++;
        end
        resp = s_bresp_o;
        @(negedge clk);
        s_bready_i = 1'b0;
    endtask

    task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                             output axil_resp_t resp);
        int waited;
        waited = 0;
        @(negedge clk);
        s_araddr_i  = addr;
        s_arvalid_i = 1'b1;
        while (!s_arready_o && waited < HS_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        @(negedge clk);   // AR taken on the posedge in between
        s_arvalid_i = 1'b0;
        s_rready_i  = 1'b1;
        waited = 0;
        while (!s_rvalid_o && waited < HS_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!s_rvalid_o) begin
            $display("%s: no read response for address %h", test_name, addr);
            error_count++;
        end
        data = s_rdata_o;
        resp = s_rresp_o;
        @(negedge clk);
        s_rready_i = 1'b0;
    endtask

    task automatic write_expect(input axil_addr_t addr, input axil_data_t data,
                                input axil_resp_t exp_resp);
        axil_resp_t resp;
        axil_write(addr, data, resp);
        check_resp($sformatf("write %h", addr), exp_resp, resp);
        if (addr < `CSR_CTRL && exp_resp == RESP_OKAY) begin
            mem_img[addr[9:2]] = data;
        end
    endtask

    task automatic read_expect(input axil_addr_t addr, input word_t exp_data,
                               input axil_resp_t exp_resp);
        axil_data_t data;
        axil_resp_t resp;
        axil_read(addr, data, resp);
        check_resp($sformatf("read %h", addr), exp_resp, resp);
        check_word($sformatf("read %h", addr), exp_data, data);
    endtask

    task automatic wait_done();
        axil_data_t st;
        axil_resp_t resp;
        int         polls;
        st = '0;
        polls = 0;
        while (!st[1] && polls < DONE_POLLS) begin
            axil_read(`CSR_STATUS, st, resp);
            polls++;
        end
        if (!st[1]) begin
            $display("%s: done flag never rose after start", test_name);
            error_count++;
        end
    endtask

    // out[r][c] = sum w[i][j] * in[r+i-1][c+j-1], zero outside the map
    task automatic compute_expected();
        word_t acc;
        int    rr;
        int    cc;
        for (int r = 0; r < FM; r++) begin
            for (int c = 0; c < FM; c++) begin
                acc = '0;
                for (int i = 0; i < WT; i++) begin
                    for (int j = 0; j < WT; j++) begin
                        rr = r + i - 1;
                        cc = c + j - 1;
                        if (rr >= 0 && rr < FM && cc >= 0 && cc < FM) begin
                            acc = acc + wt_arr[i*WT+j] * ifm_arr[rr*FM+cc];
                        end
                    end
                end
                exp_arr[r*FM+c] = acc;
            end
        end
    endtask

    task automatic set_offsets(input int wt, input int ifm, input int ofm);
        write_expect(`CSR_WT_OFS, wt, RESP_OKAY);
        write_expect(`CSR_IFM_OFS, ifm, RESP_OKAY);
        write_expect(`CSR_OFM_OFS, ofm, RESP_OKAY);
    endtask

    task automatic load_operands(input int wt, input int ifm);
        for (int k = 0; k < WT*WT; k++) begin
            write_expect(axil_addr_t'((wt + k) * 4), wt_arr[k], RESP_OKAY);
        end
        for (int k = 0; k < FM*FM; k++) begin
            write_expect(axil_addr_t'((ifm + k) * 4), ifm_arr[k], RESP_OKAY);
        end
    endtask

    task automatic random_operands();
        for (int k = 0; k < WT*WT; k++) begin
            rand_small(wt_arr[k]);
        end
        for (int k = 0; k < FM*FM; k++) begin
            rand_small(ifm_arr[k]);
        end
    endtask

    task automatic check_output(input int ofm);
        for (int k = 0; k < FM*FM; k++) begin
            mem_img[ofm+k] = exp_arr[k];
            read_expect(axil_addr_t'((ofm + k) * 4), exp_arr[k], RESP_OKAY);
        end
    endtask

    task automatic reset_regs_test();
        test_name = "reset_regs";
        read_expect(`CSR_STATUS, 32'h1, RESP_OKAY);   // idle, not done
        read_expect(`CSR_WT_OFS, 32'h0, RESP_OKAY);
        read_expect(`CSR_IFM_OFS, 32'h0, RESP_OKAY);
        read_expect(`CSR_OFM_OFS, 32'h0, RESP_OKAY);
        set_offsets(8'h12, 8'h34, 8'h56);
        read_expect(`CSR_WT_OFS, 32'h12, RESP_OKAY);
        read_expect(`CSR_IFM_OFS, 32'h34, RESP_OKAY);
        read_expect(`CSR_OFM_OFS, 32'h56, RESP_OKAY);
        read_expect(12'h7F0, 32'h0, RESP_OKAY);       // unmapped register
    endtask

    task automatic mem_window_test();
        test_name = "mem_window";
        for (int a = 0; a < DEPTH; a++) begin
            write_expect(axil_addr_t'(a * 4), fill_word(a), RESP_OKAY);
        end
        for (int a = 0; a < DEPTH; a++) begin
            read_expect(axil_addr_t'(a * 4), fill_word(a), RESP_OKAY);
        end
    endtask

    task automatic identity_test();
        test_name = "identity";
        random_operands();
        for (int k = 0; k < WT*WT; k++) begin
            wt_arr[k] = (k == (WT*WT) / 2) ? 32'd1 : 32'd0;
        end
        exp_arr = ifm_arr;   // centre tap only passes the map through
        set_offsets(0, 16, 96);
        load_operands(0, 16);
        write_expect(`CSR_CTRL, 32'h1, RESP_OKAY);
        wait_done();
        read_expect(`CSR_STATUS, 32'h3, RESP_OKAY);
        check_output(96);
    endtask

    task automatic random_test();
        test_name = "random";
        random_operands();
        compute_expected();
        set_offsets(200, 120, 40);
        load_operands(200, 120);
        write_expect(`CSR_CTRL, 32'h1, RESP_OKAY);
        wait_done();
        check_output(40);
        for (int a = 0; a < DEPTH; a++) begin
            read_expect(axil_addr_t'(a * 4), mem_img[a], RESP_OKAY);
        end
    endtask

    task automatic busy_access_test();
        test_name = "busy_access";
        random_operands();
        compute_expected();
        set_offsets(200, 120, 8);
        load_operands(200, 120);
        write_expect(`CSR_CTRL, 32'h1, RESP_OKAY);
        read_expect(`CSR_STATUS, 32'h0, RESP_OKAY);
        write_expect(axil_addr_t'(230 * 4), 32'hDEADBEEF, RESP_SLVERR);
        read_expect(axil_addr_t'(230 * 4), 32'h0, RESP_SLVERR);
        write_expect(`CSR_CTRL, 32'h1, RESP_OKAY);    // ignored second start
        wait_done();
        for (int k = 0; k < 100; k++) begin
            read_expect(`CSR_STATUS, 32'h3, RESP_OKAY);   // no second run
        end
        read_expect(axil_addr_t'(230 * 4), mem_img[230], RESP_OKAY);
        check_output(8);
    endtask

    task automatic restart_test();
        test_name = "restart";
        write_expect(`CSR_OFM_OFS, 56, RESP_OKAY);    // output lands on other contents
        write_expect(`CSR_CTRL, 32'h1, RESP_OKAY);
        read_expect(`CSR_STATUS, 32'h0, RESP_OKAY);   // done cleared while busy
        wait_done();
        read_expect(`CSR_STATUS, 32'h3, RESP_OKAY);
        check_output(56);
    endtask

    initial begin
        clk         = 1'b0;
        arst_n_i    = 1'b0;
        s_awaddr_i  = '0;
        s_awvalid_i = 1'b0;
        s_wdata_i   = '0;
        s_wvalid_i  = 1'b0;
        s_bready_i  = 1'b0;
        s_araddr_i  = '0;
        s_arvalid_i = 1'b0;
        s_rready_i  = 1'b0;
        error_count = 0;
        lfsr_q      = 16'd57302;
        test_name   = "reset";
        repeat (10) @(negedge clk);
        arst_n_i = 1'b1;

        reset_regs_test();
        mem_window_test();
        identity_test();
        random_test();
        busy_access_test();
        restart_test();

        $display("all tests finished with %0d errors", error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- include/conv_defines.svh
`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

// feature map and kernel sides
`define CONV_FM_DIM 8
`define CONV_WT_DIM 3

// scratch memory, 32-bit words
`define CONV_MEM_DEPTH 256
`define CONV_MEM_AW 8

// register window, byte addresses above the memory window
`define CSR_CTRL 12'h400
`define CSR_STATUS 12'h404
`define CSR_WT_OFS 12'h408
`define CSR_IFM_OFS 12'h40C
`define CSR_OFM_OFS 12'h410

`endif

//--- source/axil_csr_port.sv
`include "conv_defines.svh"

module axil_csr_port
    import conv_pkg::*;
    import axil_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n_i,
    input  axil_addr_t s_awaddr_i,
    input  logic       s_awvalid_i,
    output logic       s_awready_o,
    input  axil_data_t s_wdata_i,
    input  logic       s_wvalid_i,
    output logic       s_wready_o,
    output axil_resp_t s_bresp_o,
    output logic       s_bvalid_o,
    input  logic       s_bready_i,
    input  axil_addr_t s_araddr_i,
    input  logic       s_arvalid_i,
    output logic       s_arready_o,
    output axil_data_t s_rdata_o,
    output axil_resp_t s_rresp_o,
    output logic       s_rvalid_o,
    input  logic       s_rready_i,
    input  word_t      host_rdata_i,
    input  logic       done_i,
    output mem_addr_t  host_raddr_o,
    output mem_addr_t  host_waddr_o,
    output logic       host_re_o,
    output logic       host_we_o,
    output word_t      host_wdata_o,
    output logic       start_o,
    output logic       busy_o,
    output mem_addr_t  wt_ofs_o,
    output mem_addr_t  ifm_ofs_o,
    output mem_addr_t  ofm_ofs_o
);
    axil_addr_t aw_addr_q;
    axil_addr_t ar_addr_q;
    axil_addr_t wr_addr;
    axil_data_t w_data_q;
    axil_data_t wr_data;
    axil_data_t rd_data;
    logic       aw_held_q;
    logic       w_held_q;
    logic       aw_hs;
    logic       w_hs;
    logic       wr_fire;
    logic       wr_mem;
    logic       ar_hs;
    logic       rd_wait_q;   // memory read in flight
    logic       rd_err_q;
    logic       done_q;

    // write path: AW and W in any order, held until the pair is complete
    assign s_awready_o = !aw_held_q && !s_bvalid_o;
    assign s_wready_o  = !w_held_q && !s_bvalid_o;
    assign aw_hs   = s_awvalid_i && s_awready_o;
    assign w_hs    = s_wvalid_i && s_wready_o;
    assign wr_fire = (aw_held_q || aw_hs) && (w_held_q || w_hs);
    assign wr_addr = aw_held_q ? aw_addr_q : s_awaddr_i;
    assign wr_data = w_held_q ? w_data_q : s_wdata_i;
    assign wr_mem  = (wr_addr < `CSR_CTRL);

    assign host_we_o    = wr_fire && wr_mem && !busy_o;
    assign host_waddr_o = wr_addr[`CONV_MEM_AW+1:2];   // byte to word address
    assign host_wdata_o = wr_data;

    // read path: memory sampled one cycle after AR, response one cycle later
    assign s_arready_o  = !rd_wait_q && !s_rvalid_o;
    assign ar_hs        = s_arvalid_i && s_arready_o;
    assign host_re_o    = ar_hs && (s_araddr_i < `CSR_CTRL) && !busy_o;
    assign host_raddr_o = s_araddr_i[`CONV_MEM_AW+1:2];

    always_comb begin
        case (ar_addr_q)
            `CSR_STATUS:  rd_data = {30'd0, done_q, !busy_o};
            `CSR_WT_OFS:  rd_data = axil_data_t'(wt_ofs_o);
            `CSR_IFM_OFS: rd_data = axil_data_t'(ifm_ofs_o);
            `CSR_OFM_OFS: rd_data = axil_data_t'(ofm_ofs_o);
            default:      rd_data = '0;
        endcase
        if (ar_addr_q < `CSR_CTRL) begin
            rd_data = rd_err_q ? '0 : host_rdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            aw_addr_q <= s_awaddr_i;
        end
        if (w_hs) begin
            w_data_q <= s_wdata_i;
        end
        if (ar_hs) begin
            ar_addr_q <= s_araddr_i;
        end
        if (rd_wait_q) begin
            s_rdata_o <= rd_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            aw_held_q  <= 1'b0;
            w_held_q   <= 1'b0;
            s_bvalid_o <= 1'b0;
            s_bresp_o  <= RESP_OKAY;
            rd_wait_q  <= 1'b0;
            rd_err_q   <= 1'b0;
            s_rvalid_o <= 1'b0;
            s_rresp_o  <= RESP_OKAY;
            start_o    <= 1'b0;
            busy_o     <= 1'b0;
            done_q     <= 1'b0;
            wt_ofs_o   <= '0;
            ifm_ofs_o  <= '0;
            ofm_ofs_o  <= '0;
        end else begin
            if (wr_fire) begin
                aw_held_q  <= 1'b0;
                w_held_q   <= 1'b0;
                s_bvalid_o <= 1'b1;
                s_bresp_o  <= (wr_mem && busy_o) ? RESP_SLVERR : RESP_OKAY;
            end else begin
                if (aw_hs) begin
                    aw_held_q <= 1'b1;
                end
                if (w_hs) begin
                    w_held_q <= 1'b1;
                end
                if (s_bready_i) begin
                    s_bvalid_o <= 1'b0;
                end
            end

            rd_wait_q <= ar_hs;
            if (ar_hs) begin
                rd_err_q <= (s_araddr_i < `CSR_CTRL) && busy_o;
            end
            if (rd_wait_q) begin
                s_rvalid_o <= 1'b1;
                s_rresp_o  <= rd_err_q ? RESP_SLVERR : RESP_OKAY;
            end else if (s_rready_i) begin
                s_rvalid_o <= 1'b0;
            end

            start_o <= 1'b0;
            if (wr_fire && wr_addr == `CSR_CTRL && wr_data[0] && !busy_o) begin
                start_o <= 1'b1;
                busy_o  <= 1'b1;
                done_q  <= 1'b0;   // done stays low until this run ends
            end else if (done_i) begin
                busy_o <= 1'b0;
                done_q <= 1'b1;
            end

            if (wr_fire) begin
                case (wr_addr)
                    `CSR_WT_OFS:  wt_ofs_o  <= mem_addr_t'(wr_data);
                    `CSR_IFM_OFS: ifm_ofs_o <= mem_addr_t'(wr_data);
                    `CSR_OFM_OFS: ofm_ofs_o <= mem_addr_t'(wr_data);
                    default: ;
                endcase
            end
        end
    end

    // write response holds with its code until the host takes it
    bresp_hold_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        s_bvalid_o && !s_bready_i |=> s_bvalid_o && $stable(s_bresp_o));

endmodule

//--- source/axil_pkg.sv
package axil_pkg;

    typedef logic [11:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [1:0] axil_resp_t;

    localparam axil_resp_t RESP_OKAY = 2'd0;
    localparam axil_resp_t RESP_SLVERR = 2'd2;

endpackage

//--- source/conv_accel_top.sv
`include "conv_defines.svh"

module conv_accel_top
    import conv_pkg::*;
    import axil_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n_i,
    input  axil_addr_t s_awaddr_i,
    input  logic       s_awvalid_i,
    output logic       s_awready_o,
    input  axil_data_t s_wdata_i,
    input  logic       s_wvalid_i,
    output logic       s_wready_o,
    output axil_resp_t s_bresp_o,
    output logic       s_bvalid_o,
    input  logic       s_bready_i,
    input  axil_addr_t s_araddr_i,
    input  logic       s_arvalid_i,
    output logic       s_arready_o,
    output axil_data_t s_rdata_o,
    output axil_resp_t s_rresp_o,
    output logic       s_rvalid_o,
    input  logic       s_rready_i
);
    mem_addr_t host_raddr;
    mem_addr_t host_waddr;
    logic      host_re;
    logic      host_we;
    word_t     host_wdata;
    word_t     mem_rdata;        // shared by host and engine
    logic      start;
    logic      busy;
    logic      done;
    mem_addr_t wt_ofs;
    mem_addr_t ifm_ofs;
    mem_addr_t ofm_ofs;
    mem_addr_t eng_raddr;
    logic      eng_re;
    mem_addr_t eng_waddr;
    logic      eng_we;
    word_t     eng_wdata;
    logic      wt_valid;
    logic      px_valid;
    krow_t     win_row;
    kcol_t     win_col;
    word_t     win_data;
    word_t     partial [`CONV_WT_DIM];
    logic [`CONV_WT_DIM-1:0] partial_valid;

    axil_csr_port i_axil_csr_port (
        .*,                          // clock, reset and AXI ports by name
        .host_rdata_i (mem_rdata),
        .done_i       (done),
        .host_raddr_o (host_raddr),
        .host_waddr_o (host_waddr),
        .host_re_o    (host_re),
        .host_we_o    (host_we),
        .host_wdata_o (host_wdata),
        .start_o      (start),
        .busy_o       (busy),
        .wt_ofs_o     (wt_ofs),
        .ifm_ofs_o    (ifm_ofs),
        .ofm_ofs_o    (ofm_ofs)
    );

    scratch_mem i_scratch_mem (
        .clk          (clk),
        .busy_i       (busy),
        .host_raddr_i (host_raddr),
        .host_re_i    (host_re),
        .host_waddr_i (host_waddr),
        .host_we_i    (host_we),
        .host_wdata_i (host_wdata),
        .eng_raddr_i  (eng_raddr),
        .eng_re_i     (eng_re),
        .eng_waddr_i  (eng_waddr),
        .eng_we_i     (eng_we),
        .eng_wdata_i  (eng_wdata),
        .rdata_o      (mem_rdata)
    );

    window_fetch i_window_fetch (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .start_i    (start),
        .wt_ofs_i   (wt_ofs),
        .ifm_ofs_i  (ifm_ofs),
        .rdata_i    (mem_rdata),
        .raddr_o    (eng_raddr),
        .re_o       (eng_re),
        .wt_valid_o (wt_valid),
        .px_valid_o (px_valid),
        .row_o      (win_row),
        .col_o      (win_col),
        .data_o     (win_data)
    );

    for (genvar g = 0; g < `CONV_WT_DIM; g++) begin : g_lane
        mac_lane #(.ROW(krow_t'(g))) i_mac_lane (
            .clk             (clk),
            .arst_n_i        (arst_n_i),
            .wt_valid_i      (wt_valid),
            .px_valid_i      (px_valid),
            .row_i           (win_row),
            .col_i           (win_col),
            .data_i          (win_data),
            .partial_o       (partial[g]),
            .partial_valid_o (partial_valid[g])
        );
    end

    ofm_writer i_ofm_writer (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .start_i         (start),
        .ofm_ofs_i       (ofm_ofs),
        .partial_i       (partial),
        .partial_valid_i (partial_valid),
        .waddr_o         (eng_waddr),
        .we_o            (eng_we),
        .wdata_o         (eng_wdata),
        .done_o          (done)
    );

endmodule

//--- source/conv_pkg.sv
`include "conv_defines.svh"

package conv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [`CONV_MEM_AW-1:0] mem_addr_t;   // scratch word address
    typedef logic [5:0] pix_idx_t;                 // output pixel, row-major
    typedef logic [1:0] krow_t;
    typedef logic [1:0] kcol_t;

    typedef enum logic [1:0] {
        IDLE,
        LOAD_WT,   // 9 weight reads
        STREAM     // 9 window reads per output pixel
    } fetch_state_t;

endpackage

//--- source/mac_lane.sv
`include "conv_defines.svh"

module mac_lane
    import conv_pkg::*;
#(
    parameter krow_t ROW = 2'd0
) (
    input  logic  clk,
    input  logic  arst_n_i,
    input  logic  wt_valid_i,
    input  logic  px_valid_i,
    input  krow_t row_i,
    input  kcol_t col_i,
    input  word_t data_i,
    output word_t partial_o,
    output logic  partial_valid_o
);
    localparam kcol_t LAST_COL = kcol_t'(`CONV_WT_DIM - 1);

    word_t wt_q [`CONV_WT_DIM];
    word_t acc_q;
    word_t sum;
    logic  mine;
    logic  row_end;

    assign mine    = (row_i == ROW);
    assign row_end = px_valid_i && mine && (col_i == LAST_COL);
    assign sum     = acc_q + wt_q[col_i] * data_i;   // 32-bit wrap

    always_ff @(posedge clk) begin
        if (wt_valid_i && mine) begin
            wt_q[col_i] <= data_i;
        end
        if (row_end) begin
            partial_o <= sum;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            acc_q           <= '0;
            partial_valid_o <= 1'b0;
        end else begin
            partial_valid_o <= row_end;
            if (px_valid_i && mine) begin
                acc_q <= row_end ? '0 : sum;   // fresh start for next pixel
            end
        end
    end

endmodule

//--- source/ofm_writer.sv
`include "conv_defines.svh"

module ofm_writer
    import conv_pkg::*;
(
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic                    start_i,
    input  mem_addr_t               ofm_ofs_i,
    input  word_t                   partial_i [`CONV_WT_DIM],
    input  logic [`CONV_WT_DIM-1:0] partial_valid_i,
    output mem_addr_t               waddr_o,
    output logic                    we_o,
    output word_t                   wdata_o,
    output logic                    done_o
);
    localparam int LAST = `CONV_WT_DIM - 1;
    localparam pix_idx_t LAST_PIX = pix_idx_t'(`CONV_FM_DIM * `CONV_FM_DIM - 1);

    word_t    held_q [LAST];   // early rows of the current pixel
    pix_idx_t pix_q;

    always_ff @(posedge clk) begin
        for (int i = 0; i < LAST; i++) begin
            if (partial_valid_i[i]) begin
                held_q[i] <= partial_i[i];
            end
        end
    end

    always_comb begin
        wdata_o = partial_i[LAST];
        for (int i = 0; i < LAST; i++) begin
            wdata_o = wdata_o + held_q[i];
        end
    end

    // last row closes the pixel, write in the same cycle
    assign we_o    = partial_valid_i[LAST];
    assign waddr_o = ofm_ofs_i + mem_addr_t'(pix_q);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pix_q  <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= we_o && (pix_q == LAST_PIX);
            if (start_i) begin
                pix_q <= '0;
            end else if (we_o) begin
                pix_q <= pix_q + 1'b1;
            end
        end
    end

    // lane staggering keeps the held partials valid until the last row lands
    lane_stagger_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        partial_valid_i[LAST] |-> partial_valid_i[LAST-1:0] == '0);

endmodule

//--- source/scratch_mem.sv
`include "conv_defines.svh"

module scratch_mem
    import conv_pkg::*;
(
    input  logic      clk,
    input  logic      busy_i,
    input  mem_addr_t host_raddr_i,
    input  logic      host_re_i,
    input  mem_addr_t host_waddr_i,
    input  logic      host_we_i,
    input  word_t     host_wdata_i,
    input  mem_addr_t eng_raddr_i,
    input  logic      eng_re_i,
    input  mem_addr_t eng_waddr_i,
    input  logic      eng_we_i,
    input  word_t     eng_wdata_i,
    output word_t     rdata_o
);
    word_t     mem_q [`CONV_MEM_DEPTH];
    mem_addr_t raddr;
    mem_addr_t waddr;
    logic      re;
    logic      we;
    word_t     wdata;

    // the engine owns both ports for the whole run
    assign raddr = busy_i ? eng_raddr_i : host_raddr_i;
    assign re    = busy_i ? eng_re_i : host_re_i;
    assign waddr = busy_i ? eng_waddr_i : host_waddr_i;
    assign we    = busy_i ? eng_we_i : host_we_i;
    assign wdata = busy_i ? eng_wdata_i : host_wdata_i;

    always_ff @(posedge clk) begin
        if (we) begin
            mem_q[waddr] <= wdata;
        end
        if (re) begin
            rdata_o <= mem_q[raddr];   // data one cycle after address
        end
    end

    // writer must never outlive the busy flag of the register block
    eng_we_busy_a: assert property (@(posedge clk) eng_we_i |-> busy_i);

endmodule

//--- source/window_fetch.sv
`include "conv_defines.svh"

module window_fetch
    import conv_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      start_i,
    input  mem_addr_t wt_ofs_i,
    input  mem_addr_t ifm_ofs_i,
    input  word_t     rdata_i,
    output mem_addr_t raddr_o,
    output logic      re_o,
    output logic      wt_valid_o,
    output logic      px_valid_o,
    output krow_t     row_o,
    output kcol_t     col_o,
    output word_t     data_o
);
    localparam krow_t LAST_ROW = krow_t'(`CONV_WT_DIM - 1);
    localparam kcol_t LAST_COL = kcol_t'(`CONV_WT_DIM - 1);
    localparam pix_idx_t LAST_PIX = pix_idx_t'(`CONV_FM_DIM * `CONV_FM_DIM - 1);

    fetch_state_t state_q;
    pix_idx_t     pix_q;
    krow_t        krow_q;
    kcol_t        kcol_q;
    logic [3:0]   in_row;   // -1 wraps to 15, outside the map
    logic [3:0]   in_col;
    logic         pad;
    logic         pad_q;
    logic         win_end;

    assign in_row  = 4'(pix_q / `CONV_FM_DIM) + 4'(krow_q) - 4'd1;
    assign in_col  = 4'(pix_q % `CONV_FM_DIM) + 4'(kcol_q) - 4'd1;
    assign pad     = (in_row >= `CONV_FM_DIM) || (in_col >= `CONV_FM_DIM);
    assign win_end = (krow_q == LAST_ROW) && (kcol_q == LAST_COL);

    always_comb begin
        re_o    = 1'b0;
        raddr_o = ifm_ofs_i + mem_addr_t'(in_row) * mem_addr_t'(`CONV_FM_DIM)
                  + mem_addr_t'(in_col);
        if (state_q == LOAD_WT) begin
            re_o    = 1'b1;
            raddr_o = wt_ofs_i + mem_addr_t'(krow_q) * mem_addr_t'(`CONV_WT_DIM)
                      + mem_addr_t'(kcol_q);
        end else if (state_q == STREAM) begin
            re_o = !pad;   // padded taps skip the memory
        end
    end

    assign data_o = pad_q ? '0 : rdata_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= IDLE;
            pix_q      <= '0;
            krow_q     <= '0;
            kcol_q     <= '0;
            wt_valid_o <= 1'b0;
            px_valid_o <= 1'b0;
            row_o      <= '0;
            col_o      <= '0;
            pad_q      <= 1'b0;
        end else begin
            // tags trail the address by the memory latency
            wt_valid_o <= (state_q == LOAD_WT);
            px_valid_o <= (state_q == STREAM);
            row_o      <= krow_q;
            col_o      <= kcol_q;
            pad_q      <= (state_q == STREAM) && pad;
            if (state_q == IDLE) begin
                if (start_i) begin
                    state_q <= LOAD_WT;
                    pix_q   <= '0;
                    krow_q  <= '0;
                    kcol_q  <= '0;
                end
            end else begin
                kcol_q <= (kcol_q == LAST_COL) ? '0 : kcol_q + 1'b1;
                if (kcol_q == LAST_COL) begin
                    krow_q <= (krow_q == LAST_ROW) ? '0 : krow_q + 1'b1;
                end
                if (win_end && state_q == LOAD_WT) begin
                    state_q <= STREAM;
                end else if (win_end) begin
                    pix_q <= pix_q + 1'b1;
                    if (pix_q == LAST_PIX) begin
                        state_q <= IDLE;
                    end
                end
            end
        end
    end

endmodule

//--- verilog.f
+incdir+include
source/conv_pkg.sv
source/axil_pkg.sv
source/scratch_mem.sv
source/window_fetch.sv
source/mac_lane.sv
source/ofm_writer.sv
source/axil_csr_port.sv
source/conv_accel_top.sv
bench/tb_conv_accel.sv
